/* sources.f */
+incdir+sim
hw/jpeg_entropy_pkg.sv
hw/huff_code_table.sv
hw/symbol_encoder.sv
hw/bitpacker.sv
hw/entropy_coder.sv
sim/tb_entropy_coder.sv

/* Bender.yml */
package:
  name: jpeg_entropy_coder

sources:
  - files:
      - hw/jpeg_entropy_pkg.sv
      - hw/huff_code_table.sv
      - hw/symbol_encoder.sv
      - hw/bitpacker.sv
      - hw/entropy_coder.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_entropy_coder.sv

/* sim/tb_entropy_model.svh */
`ifndef TB_ENTROPY_MODEL_SVH
`define TB_ENTROPY_MODEL_SVH

// Copy of the Huffman table as it was loaded into the DUT
huff_code_t ref_code [HUFF_DEPTH];
huff_len_t  ref_len  [HUFF_DEPTH];

// Pending bits of the current segment, oldest bit first
bit         pend_bits   [$];
word_t      exp_word_q  [$];
byte_cnt_t  exp_bytes_q [$];
logic       exp_last_q  [$];

// Category is the number of bits needed for the magnitude
function automatic int amp_category(input int amp);
    int mag;
    int cat;
    mag = (amp < 0) ? -amp : amp;
    cat = 0;
    while (mag != 0) begin
        mag = mag >> 1;
        cat++;
    end
    return cat;
endfunction

// A negative amplitude is sent as the low category bits of amp - 1
function automatic int amp_bits(input int amp);
    int cat;
    cat = amp_category(amp);
    if (amp < 0) begin
        return (amp - 1) & ((1 << cat) - 1);
    end
    return amp;
endfunction

// Oldest pending bits go to the top of the word, unused bits read as ones
function automatic word_t take_word();
    word_t w;
    w = '1;
    for (int i = WORD_W - 1; i >= 0 && pend_bits.size() > 0; i--) begin
        w[i] = pend_bits.pop_front();
    end
    return w;
endfunction

task automatic append_bits(input int value, input int width);
    for (int i = width - 1; i >= 0; i--) begin
        pend_bits.push_back(value[i]);
    end
    while (pend_bits.size() >= WORD_W) begin
        exp_word_q.push_back(take_word());
        exp_bytes_q.push_back(byte_cnt_t'(8));
        exp_last_q.push_back(1'b0);
    end
endtask

task automatic append_symbol(input int run, input int amp);
    int cat;
    int addr;
    cat  = amp_category(amp);
    addr = run * 16 + cat;
    append_bits(int'(ref_code[addr]), int'(ref_len[addr]));
    append_bits(amp_bits(amp), cat);
endtask

// The flush word counts started bytes, and an empty flush counts as 8
task automatic append_marker();
    int n;
    n = pend_bits.size();
    exp_word_q.push_back(take_word());
    exp_bytes_q.push_back(byte_cnt_t'((n == 0) ? 8 : (n + 7) / 8));
    exp_last_q.push_back(1'b1);
endtask

`endif

/* sim/tb_entropy_coder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_entropy_coder
    import jpeg_entropy_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int N_RAND        = 400;
    localparam int N_HOLD        = 300;
    localparam int SEG_CNT       = 5;
    localparam int SEG_LEN       = 20;
    localparam int TABLE_ENTRIES = 16 * (MAX_SIZE + 1);
    localparam int TOTAL_SYMBOLS = 46 + (N_RAND + 1) + 65 + (N_HOLD + 1)
                                 + SEG_CNT * (SEG_LEN + 1);
    localparam int WATCHDOG_CYCLES = 4 * TOTAL_SYMBOLS + TABLE_ENTRIES;

    logic       clk;
    logic       resetn;
    logic       cfg_we;
    huff_addr_t cfg_addr;
    huff_code_t cfg_code;
    huff_len_t  cfg_len;
    logic       sym_valid;
    run_t       sym_run;
    amp_t       sym_amp;
    logic       sym_last;
    logic       sym_hold;
    word_t      out_data;
    byte_cnt_t  out_bytes;
    logic       out_last;
    logic       out_valid;
    logic       out_hold;

    logic       hold_en;
    int         checks;
    int         errors;
    int         words;
    int         test_num;
    int         words_at_start;
    int         errors_at_start;
    int         seed_ret;
    logic       held_valid;
    word_t      held_data;
    byte_cnt_t  held_bytes;

    `include "tb_entropy_model.svh"

    entropy_coder i_entropy_coder (
        .clk       (clk),
        .resetn    (resetn),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_code  (cfg_code),
        .cfg_len   (cfg_len),
        .sym_valid (sym_valid),
        .sym_run   (sym_run),
        .sym_amp   (sym_amp),
        .sym_last  (sym_last),
        .sym_hold  (sym_hold),
        .out_data  (out_data),
        .out_bytes (out_bytes),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_hold  (out_hold)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bytes(input string name, input byte_cnt_t got, input byte_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_hold(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Canonical codes, shortest first, keep the table prefix free
    task automatic load_table();
        int code;
        for (int a = 0; a < HUFF_DEPTH; a++) begin
            ref_len[a]  = '0;
            ref_code[a] = '0;
        end
        for (int run = 0; run < 16; run++) begin
            for (int s = 0; s <= MAX_SIZE; s++) begin
                ref_len[run * 16 + s] = (run == 0) ? $urandom_range(16, 5) : $urandom_range(16, 9);
            end
        end
        code = 0;
        for (int l = 1; l <= 16; l++) begin
            for (int a = 0; a < HUFF_DEPTH; a++) begin
                if (ref_len[a] == l) begin
                    ref_code[a] = huff_code_t'(code);
                    code++;
                end
            end
            code = code << 1;
        end
        for (int a = 0; a < HUFF_DEPTH; a++) begin
            if (ref_len[a] != 0) begin
                cfg_we   = 1'b1;
                cfg_addr = huff_addr_t'(a);
                cfg_code = ref_code[a];
                cfg_len  = ref_len[a];
                @(negedge clk);
            end
        end
        cfg_we = 1'b0;
    endtask

    function automatic int amp_of_size(input int size);
        int mag;
        if (size == 0) begin
            return 0;
        end
        mag = (1 << (size - 1)) + $urandom_range((1 << (size - 1)) - 1, 0);
        return $urandom_range(1, 0) ? -mag : mag;
    endfunction

    // Called on a falling edge and returns on the falling edge after acceptance
    task automatic send(input int run, input int amp, input logic last);
        sym_valid = 1'b1;
        sym_run   = run_t'(run);
        sym_amp   = amp_t'(amp);
        sym_last  = last;
        @(posedge clk);
        while (sym_hold) begin
            @(posedge clk);
        end
        if (last) begin
            append_marker();
        end else begin
            append_symbol(run, amp);
        end
        @(negedge clk);
    endtask

    task automatic send_random();
        send($urandom_range(15, 0), amp_of_size($urandom_range(MAX_SIZE, 0)), 1'b0);
    endtask

    task automatic send_marker();
        send($urandom_range(15, 0), amp_of_size($urandom_range(MAX_SIZE, 0)), 1'b1);
    endtask

    task automatic finish_test(input string name);
        sym_valid = 1'b0;
        while (exp_word_q.size() != 0) begin
            @(negedge clk);
        end
        test_num++;
        $display("test %0d %s: %0d words, %0d errors", test_num, name,
                 words - words_at_start, errors - errors_at_start);
        words_at_start  = words;
        errors_at_start = errors;
    endtask

    initial begin
        out_hold = 1'b0;
        forever begin
            @(negedge clk);
            out_hold = hold_en && ($urandom_range(3, 0) == 0);
        end
    end

    // Takes a word on every edge where the sink accepts it
    always @(posedge clk) begin
        if (resetn) begin
            // Hold is combinational from the sink back to the source
            check_hold("sym_hold", sym_hold, out_hold);
            if (held_valid) begin
                check_word("out_data held", out_data, held_data);
                check_bytes("out_bytes held", out_bytes, held_bytes);
            end
            held_valid = out_valid && out_hold;
            held_data  = out_data;
            held_bytes = out_bytes;
            if (out_valid && !out_hold) begin
                if (exp_word_q.size() == 0) begin
                    errors++;
                    $display("ERROR: DUT emitted a word that was not expected at %0t", $time);
                end else begin
                    check_word("out_data", out_data, exp_word_q.pop_front());
                    check_bytes("out_bytes", out_bytes, exp_bytes_q.pop_front());
                    check_last("out_last", out_last, exp_last_q.pop_front());
                    words++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int amp;
        int run;
        int size;
        seed_ret  = $urandom(32'hd5e1);
        resetn    = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_code  = '0;
        cfg_len   = '0;
        sym_valid = 1'b0;
        sym_run   = '0;
        sym_amp   = '0;
        sym_last  = 1'b0;
        hold_en   = 1'b0;
        checks    = 0;
        errors    = 0;
        words     = 0;
        test_num  = 0;
        words_at_start  = 0;
        errors_at_start = 0;
        held_valid      = 1'b0;
        repeat (2) @(negedge clk);
        resetn = 1'b1;
        load_table();

        for (int s = 0; s <= MAX_SIZE; s++) begin
            for (int neg = 0; neg < 2; neg++) begin
                if (!(s == 0 && neg == 1)) begin
                    amp = amp_of_size(s);
                    if ((amp < 0) != (neg == 1)) begin
                        amp = -amp;
                    end
                    send($urandom_range(15, 0), amp, 1'b0);
                    send_marker();
                end
            end
        end
        finish_test("single symbols per category");

        for (int i = 0; i < N_RAND; i++) begin
            send_random();
        end
        send_marker();
        finish_test("random stream");

        // 64 fields of one length fill a whole number of words
        run  = $urandom_range(15, 0);
        size = $urandom_range(MAX_SIZE, 1);
        for (int i = 0; i < 64; i++) begin
            send(run, amp_of_size(size), 1'b0);
        end
        send_marker();
        finish_test("word aligned flush");

        hold_en = 1'b1;
        for (int i = 0; i < N_HOLD; i++) begin
            send_random();
        end
        send_marker();
        finish_test("random out_hold");
        hold_en = 1'b0;

        for (int seg = 0; seg < SEG_CNT; seg++) begin
            for (int i = 0; i < SEG_LEN; i++) begin
                send_random();
            end
            send_marker();
        end
        finish_test("back to back segments");

        repeat (4) @(negedge clk);
        $display("summary: %0d tests, %0d words, %0d checks, %0d errors",
                 test_num, words, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/entropy_coder.sv */
`timescale 1ns/1ps
`default_nettype none

module entropy_coder
    import jpeg_entropy_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    // Host table load
    input  logic       cfg_we,
    input  huff_addr_t cfg_addr,
    input  huff_code_t cfg_code,
    input  huff_len_t  cfg_len,

    // Symbol stream
    input  logic       sym_valid,
    input  run_t       sym_run,
    input  amp_t       sym_amp,
    input  logic       sym_last,
    output logic       sym_hold,

    // Packed words
    output word_t      out_data,
    output byte_cnt_t  out_bytes,
    output logic       out_last,
    output logic       out_valid,
    input  logic       out_hold
);

    logic       tbl_rd_en;
    huff_addr_t tbl_addr;
    huff_code_t tbl_code;
    huff_len_t  tbl_len;

    codecoeff_t cc_data;
    cc_len_t    cc_length;
    logic       cc_last;
    logic       cc_valid;

    huff_code_table i_huff_code_table (
        .clk    (clk),
        .resetn (resetn),
        .we     (cfg_we),
        .waddr  (cfg_addr),
        .wcode  (cfg_code),
        .wlen   (cfg_len),
        .rd_en  (tbl_rd_en),
        .raddr  (tbl_addr),
        .rcode  (tbl_code),
        .rlen   (tbl_len)
    );

    // Hold from the packer reaches the symbol source unchanged
    symbol_encoder i_symbol_encoder (
        .clk       (clk),
        .resetn    (resetn),
        .sym_valid (sym_valid),
        .sym_run   (sym_run),
        .sym_amp   (sym_amp),
        .sym_last  (sym_last),
        .hold      (sym_hold),
        .tbl_rd_en (tbl_rd_en),
        .tbl_addr  (tbl_addr),
        .tbl_code  (tbl_code),
        .tbl_len   (tbl_len),
        .cc_data   (cc_data),
        .cc_length (cc_length),
        .cc_last   (cc_last),
        .cc_valid  (cc_valid)
    );

    bitpacker i_bitpacker (
        .clk                 (clk),
        .resetn              (resetn),
        .in_codecoeff_length (cc_length),
        .in_codecoeff        (cc_data),
        .in_tlast            (cc_last),
        .in_valid            (cc_valid),
        .in_hold             (sym_hold),
        .out_data            (out_data),
        .out_bytes           (out_bytes),
        .out_tlast           (out_last),
        .out_valid           (out_valid),
        .out_hold            (out_hold)
    );

endmodule

`default_nettype wire

/* hw/bitpacker.sv */
`timescale 1ns/1ps
`default_nettype none

module bitpacker
    import jpeg_entropy_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    input  cc_len_t    in_codecoeff_length,
    input  codecoeff_t in_codecoeff,
    input  logic       in_tlast,
    input  logic       in_valid,
    output logic       in_hold,

    output word_t      out_data,
    output byte_cnt_t  out_bytes,
    output logic       out_tlast,
    output logic       out_valid,
    input  logic       out_hold
);

    cc_len_t               bit_count;
    logic [CC_LEN_W:0]     next_bit_count;
    logic [CC_LEN_W:0]     rounded_count;
    word_t                 acc;
    logic [2*WORD_W-1:0]   window;
    word_t                 window_hi;
    word_t                 window_lo;
    logic                  accept;
    logic                  word_full;
    logic [2:0]            tbytes;

    assign in_hold = out_hold;
    assign accept  = in_valid & ~in_hold;

    assign next_bit_count = bit_count + in_codecoeff_length;
    assign rounded_count  = next_bit_count + 7;
    assign word_full      = (next_bit_count >= WORD_W);

    // New field lands right below the pending bits
    assign window = {acc, {WORD_W{1'b0}}}
                  | ({in_codecoeff, {(2*WORD_W-CODECOEFF_W){1'b0}}} >> bit_count);
    assign window_hi = window[2*WORD_W-1:WORD_W];
    assign window_lo = window[WORD_W-1:0];

    // The count wraps at 64, which is exactly one emitted word
    always_ff @(posedge clk) begin
        if (!resetn) begin
            bit_count <= '0;
            acc       <= '0;
        end else if (accept) begin
            if (in_tlast) begin
                bit_count <= '0;
                acc       <= '0;
            end else begin
                bit_count <= next_bit_count[CC_LEN_W-1:0];
                acc       <= word_full ? window_lo : window_hi;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (!in_hold) begin
            out_valid <= in_valid & (word_full | in_tlast);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && (in_tlast || word_full)) begin
            out_tlast <= in_tlast;
            if (in_tlast) begin
                // Unused low bits are padded with ones
                out_data <= window_hi | ({WORD_W{1'b1}} >> next_bit_count);
                tbytes   <= rounded_count[CC_LEN_W-1:3];
            end else begin
                out_data <= window_hi;
                tbytes   <= '0;
            end
        end
    end

    // Zero in the low byte count means a full word
    assign out_bytes = {tbytes == 3'd0, tbytes};

    a_field_fits: assert property (
        @(posedge clk) disable iff (!resetn)
        in_valid |-> (in_codecoeff_length <= CODECOEFF_W)
    );

    a_held_word_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        (out_valid && out_hold) |=> ($stable(out_data) && $stable(out_bytes))
    );

endmodule

`default_nettype wire

/* hw/symbol_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module symbol_encoder
    import jpeg_entropy_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    input  logic       sym_valid,
    input  run_t       sym_run,
    input  amp_t       sym_amp,
    input  logic       sym_last,
    input  logic       hold,

    output logic       tbl_rd_en,
    output huff_addr_t tbl_addr,
    input  huff_code_t tbl_code,
    input  huff_len_t  tbl_len,

    output codecoeff_t cc_data,
    output cc_len_t    cc_length,
    output logic       cc_last,
    output logic       cc_valid
);

    logic              accept;
    logic              amp_neg;
    logic [AMP_W-1:0]  amp_mag;
    logic [AMP_W-1:0]  amp_raw;
    logic [AMP_W-1:0]  amp_mask;
    size_t             size;

    enc_state_t        state;
    size_t             stage_size;
    logic [AMP_W-1:0]  stage_bits;

    codecoeff_t        merged;
    cc_len_t           field_len;

    // Category is the bit length of the magnitude
    function automatic size_t category(input logic [AMP_W-1:0] mag);
        size_t cat;
        cat = '0;
        for (int i = 0; i < MAX_SIZE; i++) begin
            if (mag[i]) begin
                cat = size_t'(i + 1);
            end
        end
        return cat;
    endfunction

    assign accept  = sym_valid & ~hold;
    assign amp_neg = sym_amp[AMP_W-1];
    assign amp_mag = amp_neg ? AMP_W'(-sym_amp) : AMP_W'(sym_amp);
    assign size    = category(amp_mag);

    // Negative amplitudes are sent as the low bits of amp - 1
    assign amp_raw  = amp_neg ? AMP_W'(sym_amp - 1) : AMP_W'(sym_amp);
    assign amp_mask = {AMP_W{1'b1}} >> (AMP_W - size);

    assign tbl_rd_en = accept & ~sym_last;
    assign tbl_addr  = {sym_run, size};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ENC_EMPTY;
        end else if (!hold) begin
            if (!sym_valid) begin
                state <= ENC_EMPTY;
            end else if (sym_last) begin
                state <= ENC_MARKER;
            end else begin
                state <= ENC_SYMBOL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !sym_last) begin
            stage_size <= size;
            stage_bits <= amp_raw & amp_mask;
        end
    end

    // Code in the upper part, amplitude bits right below it
    assign merged    = (codecoeff_t'(tbl_code) << stage_size) | codecoeff_t'(stage_bits);
    assign field_len = cc_len_t'(tbl_len) + cc_len_t'(stage_size);

    always_comb begin
        cc_valid  = (state != ENC_EMPTY);
        cc_last   = (state == ENC_MARKER);
        cc_length = '0;
        cc_data   = '0;
        if (state == ENC_SYMBOL) begin
            cc_length = field_len;
            // Stray code bits above the length fall off the top here
            cc_data   = merged << (CODECOEFF_W - field_len);
        end
    end

    a_symbol_entry_used: assert property (
        @(posedge clk) disable iff (!resetn)
        (state == ENC_SYMBOL) |-> (tbl_len != '0)
    );

endmodule

`default_nettype wire

/* hw/huff_code_table.sv */
`timescale 1ns/1ps
`default_nettype none

module huff_code_table
    import jpeg_entropy_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    // Host write port
    input  logic       we,
    input  huff_addr_t waddr,
    input  huff_code_t wcode,
    input  huff_len_t  wlen,

    // Encoder read port
    input  logic       rd_en,
    input  huff_addr_t raddr,
    output huff_code_t rcode,
    output huff_len_t  rlen
);

    huff_code_t code_mem [HUFF_DEPTH];
    huff_len_t  len_mem  [HUFF_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            code_mem[waddr] <= wcode;
        end
    end

    // A length of zero marks an unused entry, so every entry starts unused
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < HUFF_DEPTH; i++) begin
                len_mem[i] <= '0;
            end
        end else if (we) begin
            len_mem[waddr] <= wlen;
        end
    end

    // Read port holds its value while the pipeline is stalled
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rcode <= code_mem[raddr];
            rlen  <= len_mem[raddr];
        end
    end

    // The host finishes loading before any symbol is looked up
    a_no_load_during_lookup: assert property (
        @(posedge clk) disable iff (!resetn)
        !(we && rd_en)
    );

endmodule

`default_nettype wire

/* hw/jpeg_entropy_pkg.sv */
`default_nettype none

package jpeg_entropy_pkg;

    // Merged Huffman code plus amplitude bits, left-aligned
    localparam int CODECOEFF_W = 52;
    localparam int CC_LEN_W    = 6;
    localparam int WORD_W      = 64;
    localparam int BYTE_CNT_W  = 4;

    localparam int RUN_W       = 4;
    localparam int AMP_W       = 12;
    localparam int SIZE_W      = 4;
    // Largest amplitude category that the 12-bit input can produce
    localparam int MAX_SIZE    = 11;

    localparam int HUFF_ADDR_W = 8;
    localparam int HUFF_CODE_W = 16;
    localparam int HUFF_LEN_W  = 5;
    localparam int HUFF_DEPTH  = 256;

    typedef logic [CODECOEFF_W-1:0] codecoeff_t;
    typedef logic [CC_LEN_W-1:0]    cc_len_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [BYTE_CNT_W-1:0]  byte_cnt_t;

    typedef logic [RUN_W-1:0]        run_t;
    typedef logic signed [AMP_W-1:0] amp_t;
    typedef logic [SIZE_W-1:0]       size_t;

    typedef logic [HUFF_ADDR_W-1:0] huff_addr_t;
    typedef logic [HUFF_CODE_W-1:0] huff_code_t;
    typedef logic [HUFF_LEN_W-1:0]  huff_len_t;

    typedef enum logic [1:0] {
        ENC_EMPTY,
        ENC_SYMBOL,
        ENC_MARKER
    } enc_state_t;

endpackage

`default_nettype wire
